// File: Bender.yml
package:
  name: sensor_monitor

sources:
  - sensor_pkg.sv
  - sensor_bus_arbiter.sv
  - internal_sensor_poller.sv
  - aux_channel_scanner.sv
  - sensor_monitor.sv
  - target: test
    files:
      - sensor_monitor_assert.sv
      - tb_sensor_monitor.sv

// File: aux_channel_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module aux_channel_scanner (
	input  wire                                   clk,
	input  wire                                   rst_n,
	output logic                                  req,
	output sensor_pkg::drp_addr_t                 addr,
	input  wire logic                             rd_valid,
	input  wire sensor_pkg::drp_data_t            rd_data,
	output logic [sensor_pkg::NUM_AUX*12-1:0]     aux_codes,	// Channel n at n*12 +: 12
	output logic                                  sweep_done
);

	sensor_pkg::scan_state_t state;
	sensor_pkg::aux_idx_t    ch;		// Current channel
	sensor_pkg::aux_idx_t    ch_next;
	sensor_pkg::adc_code_t   rd_code;
	logic [sensor_pkg::NUM_AUX-1:0] above;	// Enabled channels past ch

	assign ch_next = ch + 1'b1;
	assign rd_code = rd_data[15:4];
	assign above   = sensor_pkg::AUX_ENABLE & ~((16'd2 << ch) - 16'd1);

	assign req  = (state == sensor_pkg::SCAN_REQ);
	assign addr = sensor_pkg::ADDR_AUX_BASE + sensor_pkg::drp_addr_t'(ch);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= sensor_pkg::SCAN_FIND;
			ch         <= '0;
			aux_codes  <= '0;	// Disabled slots stay zero
			sweep_done <= 1'b0;
		end else begin
			sweep_done <= 1'b0;
			case (state)
				sensor_pkg::SCAN_FIND: begin	// Skip one disabled channel per cycle
					if (sensor_pkg::AUX_ENABLE[ch])
						state <= sensor_pkg::SCAN_REQ;
					else
						ch <= ch_next;
				end
				default: begin
					if (rd_valid) begin
						aux_codes[ch * 12 +: 12] <= rd_code;
						sweep_done <= (above == '0);	// Last enabled channel done
						ch         <= ch_next;
						// Neighbour enabled, keep req up with the new address
						if (!sensor_pkg::AUX_ENABLE[ch_next])
							state <= sensor_pkg::SCAN_FIND;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: internal_sensor_poller.sv
`timescale 1ns/1ps
`default_nettype none

module internal_sensor_poller (
	input  wire                        clk,
	input  wire                        rst_n,
	output logic                       req,
	output sensor_pkg::drp_addr_t      addr,
	input  wire logic                  rd_valid,
	input  wire sensor_pkg::drp_data_t rd_data,
	output sensor_pkg::fix88_t         die_temp,
	output sensor_pkg::fix88_t         volt_core,
	output sensor_pkg::fix88_t         volt_aux,
	output sensor_pkg::fix88_t         volt_ram,
	output logic                       sweep_done
);

	sensor_pkg::poller_state_t state;
	logic [1:0] sel;	// 0 temp, 1 vccint, 2 vccaux, 3 vccbram

	// Multiplier pipeline with a sensor index tag per stage
	sensor_pkg::adc_code_t mult_a;
	sensor_pkg::gain_t     mult_b;
	logic [31:0] prod1;
	logic [31:0] prod2;
	logic        v1, v2, v3;
	logic [1:0]  t1, t2, t3;
	logic [31:0] temp_full;

	assign req = (state == sensor_pkg::POLL_REQ);

	always_comb begin
		case (sel)
			2'd0:    addr = sensor_pkg::ADDR_TEMP;
			2'd1:    addr = sensor_pkg::ADDR_VCCINT;
			2'd2:    addr = sensor_pkg::ADDR_VCCAUX;
			default: addr = sensor_pkg::ADDR_VCCBRAM;
		endcase
	end

	// Sequencer waits for the stored result before the next request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= sensor_pkg::POLL_REQ;
			sel   <= 2'd0;
		end else begin
			case (state)
				sensor_pkg::POLL_REQ: begin
					if (rd_valid)
						state <= sensor_pkg::POLL_CONV;
				end
				default: begin
					if (v3) begin	// Output written this edge
						sel   <= sel + 2'd1;	// Wraps back to temp
						state <= sensor_pkg::POLL_REQ;
					end
				end
			endcase
		end
	end

	// Operand, product and product delay stages
	always_ff @(posedge clk) begin
		mult_a <= rd_data[15:4];	// Drop the four LSBs
		mult_b <= (sel == 2'd0) ? sensor_pkg::TEMP_GAIN : sensor_pkg::VOLT_GAIN;
		prod1  <= mult_a * mult_b;
		prod2  <= prod1;
	end

	// Stage valids and tags
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
			t1 <= 2'd0;
			t2 <= 2'd0;
			t3 <= 2'd0;
		end else begin
			v1 <= rd_valid;
			v2 <= v1;
			v3 <= v2;
			t1 <= sel;
			t2 <= t1;
			t3 <= t2;
		end
	end

	// Shift 12 for the divide, keep 8 fraction bits, then subtract the offset
	assign temp_full = {12'd0, prod2[31:12]} - {15'd0, sensor_pkg::TEMP_OFFSET};

	// Result registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			die_temp   <= '0;
			volt_core  <= '0;
			volt_aux   <= '0;
			volt_ram   <= '0;
			sweep_done <= 1'b0;
		end else begin
			sweep_done <= v3 && (t3 == 2'd3);	// VCCBRAM closes the sweep
			if (v3) begin
				case (t3)
					2'd0:    die_temp  <= temp_full[15:0];
					2'd1:    volt_core <= prod2[19:4];	// Net shift of 4
					2'd2:    volt_aux  <= prod2[19:4];
					default: volt_ram  <= prod2[19:4];
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: project.f
sensor_pkg.sv
sensor_bus_arbiter.sv
internal_sensor_poller.sv
aux_channel_scanner.sv
sensor_monitor.sv
sensor_monitor_assert.sv
tb_sensor_monitor.sv

// File: sensor_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_bus_arbiter (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire logic              int_req,		// Internal poller
	input  wire sensor_pkg::drp_addr_t int_addr,
	input  wire logic              aux_req,		// Aux scanner
	input  wire sensor_pkg::drp_addr_t aux_addr,
	output logic                   int_rd_valid,
	output logic                   aux_rd_valid,
	output sensor_pkg::drp_data_t  rd_data,
	output logic                   drp_en,
	output sensor_pkg::drp_addr_t  drp_addr,
	input  wire sensor_pkg::drp_data_t drp_dout,
	input  wire logic              drp_ready,
	output logic                   adc_reset
);

	sensor_pkg::arb_state_t state;
	logic [8:0] count;		// Hold / settle timer
	logic       owner_aux;	// Owner of the open read, also last served
	logic       grant_aux;

	// Round robin, aux wins a tie only if int was served last
	assign grant_aux = aux_req && (!int_req || !owner_aux);

	// Ready pulse goes straight back to whoever owns the read
	assign int_rd_valid = drp_ready && (state == sensor_pkg::ARB_BUSY) && !owner_aux;
	assign aux_rd_valid = drp_ready && (state == sensor_pkg::ARB_BUSY) && owner_aux;
	assign rd_data      = drp_dout;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= sensor_pkg::ARB_HOLD;
			count     <= '0;
			adc_reset <= 1'b1;	// ADC held in reset from power-up
			drp_en    <= 1'b0;
			drp_addr  <= '0;
			owner_aux <= 1'b0;
		end else begin
			drp_en <= 1'b0;	// Single cycle strobe
			case (state)
				sensor_pkg::ARB_HOLD: begin
					count <= count + 9'd1;
					if (count == 9'(sensor_pkg::RESET_HOLD_CYCLES - 1)) begin
						count     <= '0;
						adc_reset <= 1'b0;
						state     <= sensor_pkg::ARB_SETTLE;
					end
				end
				sensor_pkg::ARB_SETTLE: begin	// Let the ADC calibrate
					count <= count + 9'd1;
					if (count == 9'(sensor_pkg::SETTLE_CYCLES - 1))
						state <= sensor_pkg::ARB_IDLE;
				end
				sensor_pkg::ARB_IDLE: begin
					if (int_req || aux_req) begin
						drp_en    <= 1'b1;
						drp_addr  <= grant_aux ? aux_addr : int_addr;
						owner_aux <= grant_aux;
						state     <= sensor_pkg::ARB_BUSY;
					end
				end
				default: begin	// One read outstanding
					if (drp_ready)
						state <= sensor_pkg::ARB_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: sensor_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_monitor (
	input  wire                                   clk,
	input  wire                                   rst_n,
	// ADC register port
	output wire logic                             drp_en,
	output wire sensor_pkg::drp_addr_t            drp_addr,
	output wire logic                             adc_reset,
	input  wire sensor_pkg::drp_data_t            drp_dout,
	input  wire logic                             drp_ready,
	// Converted readings
	output wire sensor_pkg::fix88_t               die_temp,
	output wire sensor_pkg::fix88_t               volt_core,
	output wire sensor_pkg::fix88_t               volt_aux,
	output wire sensor_pkg::fix88_t               volt_ram,
	output wire logic [sensor_pkg::NUM_AUX*12-1:0] aux_codes,
	output wire logic                             int_sweep_done,
	output wire logic                             aux_sweep_done
);

	// Peer side of the arbiter
	wire logic                  int_req;
	wire sensor_pkg::drp_addr_t int_addr;
	wire logic                  int_rd_valid;
	wire logic                  aux_req;
	wire sensor_pkg::drp_addr_t aux_addr;
	wire logic                  aux_rd_valid;
	wire sensor_pkg::drp_data_t rd_data;	// Shared by both peers

	sensor_bus_arbiter u_arbiter (
		.clk          (clk),
		.rst_n        (rst_n),
		.int_req      (int_req),
		.int_addr     (int_addr),
		.aux_req      (aux_req),
		.aux_addr     (aux_addr),
		.int_rd_valid (int_rd_valid),
		.aux_rd_valid (aux_rd_valid),
		.rd_data      (rd_data),
		.drp_en       (drp_en),
		.drp_addr     (drp_addr),
		.drp_dout     (drp_dout),
		.drp_ready    (drp_ready),
		.adc_reset    (adc_reset)
	);

	internal_sensor_poller u_internal (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (int_req),
		.addr       (int_addr),
		.rd_valid   (int_rd_valid),
		.rd_data    (rd_data),
		.die_temp   (die_temp),
		.volt_core  (volt_core),
		.volt_aux   (volt_aux),
		.volt_ram   (volt_ram),
		.sweep_done (int_sweep_done)
	);

	aux_channel_scanner u_aux (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (aux_req),
		.addr       (aux_addr),
		.rd_valid   (aux_rd_valid),
		.rd_data    (rd_data),
		.aux_codes  (aux_codes),
		.sweep_done (aux_sweep_done)
	);

endmodule

`default_nettype wire

// File: sensor_monitor_assert.sv
`timescale 1ns/1ps
`default_nettype none

module sensor_monitor_assert (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic drp_en,
	input wire logic drp_ready,
	input wire logic adc_reset,
	input wire logic int_rd_valid,
	input wire logic aux_rd_valid
);

	logic open_read;	// Strobe sent, ready not yet back

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			open_read <= 1'b0;
		else if (drp_en)
			open_read <= 1'b1;
		else if (drp_ready)
			open_read <= 1'b0;
	end

	// One read in flight on the register port
	a_single_read: assert property (@(posedge clk) disable iff (!rst_n) drp_en |-> !open_read)
		else $error("drp_en issued while a read was still outstanding");

	a_quiet_in_reset: assert property (@(posedge clk) disable iff (!rst_n) adc_reset |-> !drp_en)
		else $error("drp_en issued while the ADC was held in reset");

	// Read-valid only for an open read and only to one peer
	a_one_valid: assert property (@(posedge clk) disable iff (!rst_n)
		(int_rd_valid || aux_rd_valid) |-> open_read && !(int_rd_valid && aux_rd_valid))
		else $error("read-valid pulse without an open read or to both peers at once");

endmodule

bind sensor_bus_arbiter sensor_monitor_assert u_assert (
	.clk          (clk),
	.rst_n        (rst_n),
	.drp_en       (drp_en),
	.drp_ready    (drp_ready),
	.adc_reset    (adc_reset),
	.int_rd_valid (int_rd_valid),
	.aux_rd_valid (aux_rd_valid)
);

`default_nettype wire

// File: sensor_pkg.sv
`default_nettype none

package sensor_pkg;

	// Register port and reading widths
	typedef logic [11:0] adc_code_t;	// Top 12 bits of a result word
	typedef logic [15:0] drp_data_t;
	typedef logic [6:0]  drp_addr_t;
	typedef logic [15:0] fix88_t;		// 8.8, LSB is 1/256 V or degC
	typedef logic [16:0] gain_t;		// Multiplier constant operand

	// Status register map
	localparam drp_addr_t ADDR_TEMP     = 7'd0;
	localparam drp_addr_t ADDR_VCCINT   = 7'd1;
	localparam drp_addr_t ADDR_VCCAUX   = 7'd2;
	localparam drp_addr_t ADDR_VCCBRAM  = 7'd6;
	localparam drp_addr_t ADDR_AUX_BASE = 7'd16;	// Aux channel 0 result

	localparam int NUM_AUX = 16;
	typedef logic [$clog2(NUM_AUX)-1:0] aux_idx_t;
	localparam logic [NUM_AUX-1:0] AUX_ENABLE = 16'h8C35;	// Channels read by the scanner

	// Temp = code * 503.975 / 4096 - 273.15, both constants in 8.8
	localparam gain_t       TEMP_GAIN   = 17'h1F7F9;
	localparam logic [16:0] TEMP_OFFSET = 17'h11126;
	// Supply = code * 3 / 4096
	localparam gain_t       VOLT_GAIN   = 17'd3;

	// Power-up sequence lengths in clk cycles
	localparam int RESET_HOLD_CYCLES = 256;
	localparam int SETTLE_CYCLES     = 256;

	typedef enum logic [1:0] {ARB_HOLD, ARB_SETTLE, ARB_IDLE, ARB_BUSY} arb_state_t;
	typedef enum logic {POLL_REQ, POLL_CONV} poller_state_t;
	typedef enum logic {SCAN_FIND, SCAN_REQ} scan_state_t;

endpackage

`default_nettype wire

// File: tb_sensor_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sensor_monitor;

	// Worst case per read: grant, latency 8, back to idle, doubled for the other peer
	localparam int READ_CYCLES = 2 * (1 + 8 + 1);
	localparam int INT_SWEEP   = 4 * (READ_CYCLES + 4);	// Plus conversion
	localparam int AUX_SWEEP   = sensor_pkg::NUM_AUX * (READ_CYCLES + 1);
	localparam int LIMIT       = 10 + sensor_pkg::RESET_HOLD_CYCLES + sensor_pkg::SETTLE_CYCLES
		+ 12 * (INT_SWEEP + AUX_SWEEP);

	logic clk;
	logic rst_n;
	logic drp_en;
	logic adc_reset;
	logic drp_ready;
	sensor_pkg::drp_addr_t drp_addr;
	sensor_pkg::drp_data_t drp_dout;
	sensor_pkg::fix88_t die_temp;
	sensor_pkg::fix88_t volt_core;
	sensor_pkg::fix88_t volt_aux;
	sensor_pkg::fix88_t volt_ram;
	logic [sensor_pkg::NUM_AUX*12-1:0] aux_codes;
	logic int_sweep_done;
	logic aux_sweep_done;

	sensor_pkg::drp_data_t adc_table [0:127];	// Word returned per register address
	logic [31:0] lfsr = 32'h9e9d;
	int value_errors = 0;
	int other_errors = 0;
	int cycles = 0;

	sensor_monitor u_sensor_monitor (
		.clk            (clk),
		.rst_n          (rst_n),
		.drp_en         (drp_en),
		.drp_addr       (drp_addr),
		.adc_reset      (adc_reset),
		.drp_dout       (drp_dout),
		.drp_ready      (drp_ready),
		.die_temp       (die_temp),
		.volt_core      (volt_core),
		.volt_aux       (volt_aux),
		.volt_ram       (volt_ram),
		.aux_codes      (aux_codes),
		.int_sweep_done (int_sweep_done),
		.aux_sweep_done (aux_sweep_done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	// Galois form, polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] value);
		int i;
		value = '0;
		for (i = 0; i < n; i++) begin
			lfsr  = lfsr_next(lfsr);
			value = {value[14:0], lfsr[0]};	// One step per bit
		end
	endtask

	// Register port model, one read at a time
	initial begin : drp_model
		sensor_pkg::drp_addr_t req_addr;
		logic [15:0] lat;
		drp_ready = 1'b0;
		drp_dout  = '0;
		forever begin
			@(posedge clk);
			if (drp_en) begin
				req_addr = drp_addr;
				draw_bits(3, lat);	// Latency 1 to 8
				repeat (lat) @(posedge clk);
				#1;
				drp_dout  = adc_table[req_addr];
				drp_ready = 1'b1;
				@(posedge clk);
				#1 drp_ready = 1'b0;
			end
		end
	end

	// Reference conversions
	function automatic sensor_pkg::fix88_t temp_fix88(input sensor_pkg::drp_data_t word);
		logic [31:0] prod;
		logic [31:0] diff;
		prod = 32'(word[15:4]) * 32'(sensor_pkg::TEMP_GAIN);
		diff = {12'd0, prod[31:12]} - 32'(sensor_pkg::TEMP_OFFSET);
		return diff[15:0];
	endfunction

	function automatic sensor_pkg::fix88_t volt_fix88(input sensor_pkg::drp_data_t word);
		logic [31:0] prod;
		prod = 32'(word[15:4]) * 32'(sensor_pkg::VOLT_GAIN);
		return prod[19:4];
	endfunction

	task automatic compare_word(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got == exp) else begin
			value_errors++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic wait_int_sweeps(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge clk);
			if (int_sweep_done)
				seen++;
		end
	endtask

	task automatic wait_aux_sweeps(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge clk);
			if (aux_sweep_done)
				seen++;
		end
	endtask

	task automatic check_internal_outputs();
		compare_word("die_temp", die_temp, temp_fix88(adc_table[sensor_pkg::ADDR_TEMP]));
		compare_word("volt_core", volt_core, volt_fix88(adc_table[sensor_pkg::ADDR_VCCINT]));
		compare_word("volt_aux", volt_aux, volt_fix88(adc_table[sensor_pkg::ADDR_VCCAUX]));
		compare_word("volt_ram", volt_ram, volt_fix88(adc_table[sensor_pkg::ADDR_VCCBRAM]));
	endtask

	task automatic check_aux_outputs();
		int n;
		logic [11:0] exp;
		for (n = 0; n < sensor_pkg::NUM_AUX; n++) begin
			exp = sensor_pkg::AUX_ENABLE[n] ? adc_table[sensor_pkg::ADDR_AUX_BASE + n][15:4] : 12'h0;
			compare_word($sformatf("aux_codes[%0d]", n), 16'(aux_codes[n*12 +: 12]), 16'(exp));
		end
	endtask

	task automatic power_up_sequence();
		int high_cycles;
		bit released;
		int i;
		high_cycles = 0;
		released    = 0;
		for (i = 0; i < sensor_pkg::RESET_HOLD_CYCLES + sensor_pkg::SETTLE_CYCLES; i++) begin
			@(negedge clk);
			if (adc_reset) begin
				high_cycles++;
				assert (!released) else begin
					other_errors++;
					$display("adc_reset went high again after the hold phase ended");
				end
			end else
				released = 1;
			assert (!drp_en) else begin
				value_errors++;
				$display("FAILED drp_en: got %h expected %h during power-up", drp_en, 1'b0);
			end
		end
		compare_word("adc_reset high cycles", 16'(high_cycles), 16'(sensor_pkg::RESET_HOLD_CYCLES));
	endtask

	task automatic temperature_reading(input sensor_pkg::drp_data_t word);
		adc_table[sensor_pkg::ADDR_TEMP] = word;
		wait_int_sweeps(2);	// First sweep may carry the old code
		compare_word("die_temp", die_temp, temp_fix88(word));
	endtask

	task automatic supply_readings(input sensor_pkg::drp_data_t core,
		input sensor_pkg::drp_data_t aux, input sensor_pkg::drp_data_t ram);
		adc_table[sensor_pkg::ADDR_VCCINT]  = core;	// Distinct words expose a swapped mapping
		adc_table[sensor_pkg::ADDR_VCCAUX]  = aux;
		adc_table[sensor_pkg::ADDR_VCCBRAM] = ram;
		wait_int_sweeps(2);
		check_internal_outputs();
	endtask

	task automatic aux_channel_codes();
		int n;
		logic [15:0] word;
		for (n = 0; n < sensor_pkg::NUM_AUX; n++) begin
			draw_bits(16, word);
			adc_table[sensor_pkg::ADDR_AUX_BASE + n] = word;	// Disabled ones too
		end
		wait_aux_sweeps(2);
		check_aux_outputs();
	endtask

	task automatic peer_sharing();
		int int_seen;
		int aux_seen;
		int_seen = 0;
		aux_seen = 0;
		while (int_seen < 3 || aux_seen < 3) begin	// Timeout catches starvation
			@(negedge clk);
			if (int_sweep_done)
				int_seen++;
			if (aux_sweep_done)
				aux_seen++;
		end
	endtask

	task automatic value_tracking();
		logic [15:0] word;
		int n;
		draw_bits(16, word);
		adc_table[sensor_pkg::ADDR_TEMP] = word;
		draw_bits(16, word);
		adc_table[sensor_pkg::ADDR_VCCINT] = word;
		draw_bits(16, word);
		adc_table[sensor_pkg::ADDR_VCCAUX] = word;
		draw_bits(16, word);
		adc_table[sensor_pkg::ADDR_VCCBRAM] = word;
		for (n = 0; n < sensor_pkg::NUM_AUX; n++) begin
			draw_bits(16, word);
			adc_table[sensor_pkg::ADDR_AUX_BASE + n] = word;
		end
		wait_int_sweeps(2);
		check_internal_outputs();
		wait_aux_sweeps(2);
		check_aux_outputs();
	endtask

	initial begin : main
		int a;
		rst_n = 1'b0;
		for (a = 0; a < 128; a++)
			adc_table[a] = {a[6:0], ~a[6:0], 2'b01};	// Every address differs
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		power_up_sequence();
		temperature_reading(16'hA3C0);
		supply_readings(16'h5550, 16'h9990, 16'h5560);
		aux_channel_codes();
		peer_sharing();
		value_tracking();
		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Run limit from reset, power-up and twelve worst case sweeps of each peer
	initial begin : watchdog
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		other_errors++;
		$display("Timeout after %0d cycles, the sweeps did not complete in time", cycles);
		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
